//--- logic/reorder_buffer.sv
//--------------------
// Reorder buffer
// Holds results at their sequence-number slot and retires
// them in program order, one per cycle
//--------------------

module reorder_buffer #(
  parameter int seq_num_bits   = wb_pkg::seq_num_bits_default,
  parameter int phys_addr_bits = wb_pkg::phys_addr_bits_default
) (
  input  logic                             clk,
  input  logic                             rst,

  // Insert side from the writeback register
  input  logic                             wb_val,
  input  logic [seq_num_bits-1:0]          wb_seq_num,
  input  logic [wb_pkg::xlen-1:0]          wb_pc,
  input  logic [wb_pkg::arch_reg_bits-1:0] wb_waddr,
  input  logic [wb_pkg::xlen-1:0]          wb_wdata,
  input  logic                             wb_wen,
  input  logic [phys_addr_bits-1:0]        wb_ppreg,

  // Commit port
  output logic                             commit_val,
  output logic [seq_num_bits-1:0]          commit_seq_num,
  output logic [wb_pkg::xlen-1:0]          commit_pc,
  output logic [wb_pkg::arch_reg_bits-1:0] commit_waddr,
  output logic [wb_pkg::xlen-1:0]          commit_wdata,
  output logic                             commit_wen,
  output logic [phys_addr_bits-1:0]        commit_ppreg
);

  // One slot per sequence number
  localparam int depth = 2 ** seq_num_bits;

  //--------------------
  // Entry storage
  //--------------------

  logic [wb_pkg::xlen-1:0]          pc_mem    [depth];
  logic [wb_pkg::arch_reg_bits-1:0] waddr_mem [depth];
  logic [wb_pkg::xlen-1:0]          wdata_mem [depth];
  logic                             wen_mem   [depth];
  logic [phys_addr_bits-1:0]        ppreg_mem [depth];

  always_ff @(posedge clk) begin
    if (wb_val) begin
      pc_mem[wb_seq_num]    <= wb_pc;
      waddr_mem[wb_seq_num] <= wb_waddr;
      wdata_mem[wb_seq_num] <= wb_wdata;
      // Register zero never gets written back
      wen_mem[wb_seq_num]   <= wb_wen && (wb_waddr != '0);
      ppreg_mem[wb_seq_num] <= wb_ppreg;
    end
  end

  //--------------------
  // Filled bits and head
  //--------------------

  logic [depth-1:0]        filled;
  logic [seq_num_bits-1:0] head;

  always_ff @(posedge clk) begin
    if (rst) begin
      filled <= '0;
      head   <= '0;
    end else begin
      if (commit_val) begin
        filled[head] <= 1'b0;
        head         <= head + seq_num_bits'(1);
      end
      if (wb_val) begin
        filled[wb_seq_num] <= 1'b1;
      end
    end
  end

  // Head entry retires as soon as it is filled, no back-pressure
  assign commit_val     = filled[head];
  assign commit_seq_num = head;
  assign commit_pc      = pc_mem[head];
  assign commit_waddr   = waddr_mem[head];
  assign commit_wdata   = wdata_mem[head];
  assign commit_wen     = wen_mem[head];
  assign commit_ppreg   = ppreg_mem[head];

  //--------------------
  // Checks
  //--------------------

  // Issue side must keep no more than depth results in flight
  a_no_overwrite: assert property (
    @(posedge clk) disable iff (rst)
    wb_val |-> !filled[wb_seq_num]
  );

endmodule

//--- logic/seq_arbiter.sv
//--------------------
// Sequence arbiter
// Grants the valid pipe whose sequence number is oldest
// relative to its own count of committed results
//--------------------

module seq_arbiter #(
  parameter int num_pipes    = wb_pkg::num_pipes_default,
  parameter int seq_num_bits = wb_pkg::seq_num_bits_default
) (
  input  logic                                     clk,
  input  logic                                     rst,

  input  logic [num_pipes-1:0]                     val,
  input  logic [num_pipes-1:0][seq_num_bits-1:0]   seq_num,
  input  logic                                     commit_val,

  output logic [num_pipes-1:0]                     gnt
);

  //--------------------
  // Head count
  //--------------------

  // Tracks the reorder-buffer head by counting commits
  logic [seq_num_bits-1:0] head;

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (commit_val) begin
      head <= head + seq_num_bits'(1);
    end
  end

  //--------------------
  // Age compare
  //--------------------

  // Distance from the head modulo the buffer depth
  logic [num_pipes-1:0][seq_num_bits-1:0] age;

  always_comb begin
    for (int p = 0; p < num_pipes; p++) begin
      age[p] = seq_num[p] - head;
    end
  end

  // Linear scan for the smallest age
  logic                    found;
  logic [seq_num_bits-1:0] best_age;

  always_comb begin
    found    = 1'b0;
    best_age = '1;
    gnt      = '0;
    for (int p = 0; p < num_pipes; p++) begin
      if (val[p] && (!found || age[p] < best_age)) begin
        found    = 1'b1;
        best_age = age[p];
        gnt      = '0;
        gnt[p]   = 1'b1;
      end
    end
  end

  //--------------------
  // Checks
  //--------------------

  // At most one grant and only to a valid pipe
  a_gnt_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(gnt) && ((gnt & ~val) == '0)
  );

  // A pipe that loses keeps waiting until it is granted
  for (genvar p = 0; p < num_pipes; p++) begin : g_held
    a_val_held: assert property (
      @(posedge clk) disable iff (rst)
      (val[p] && !gnt[p]) |=> val[p]
    );
  end

endmodule

//--- logic/wb_pkg.sv
//--------------------
// Writeback package
// Shared widths and default parameter values for the
// writeback and commit unit
//--------------------

package wb_pkg;

  //--------------------
  // Fixed widths
  //--------------------

  // Data and pc word width
  localparam int xlen = 32;

  // Architectural register specifier
  localparam int arch_reg_bits = 5;

  //--------------------
  // Defaults for the top-level parameters
  //--------------------

  // Execute pipes feeding the writeback stage
  localparam int num_pipes_default = 3;

  // Sequence-number width, the reorder buffer holds 2**n entries
  localparam int seq_num_bits_default = 3;

  // Physical register specifier
  localparam int phys_addr_bits_default = 6;

endpackage

//--- logic/writeback_commit_unit.sv
//--------------------
// Writeback and commit unit
// Writeback selection followed by in-order commit
//--------------------

module writeback_commit_unit #(
  parameter int num_pipes      = wb_pkg::num_pipes_default,
  parameter int seq_num_bits   = wb_pkg::seq_num_bits_default,
  parameter int phys_addr_bits = wb_pkg::phys_addr_bits_default
) (
  input  logic                                             clk,
  input  logic                                             rst,

  // Execute pipes
  input  logic [num_pipes-1:0]                             ex_val,
  input  logic [num_pipes-1:0][wb_pkg::xlen-1:0]           ex_pc,
  input  logic [num_pipes-1:0][seq_num_bits-1:0]           ex_seq_num,
  input  logic [num_pipes-1:0][wb_pkg::arch_reg_bits-1:0]  ex_waddr,
  input  logic [num_pipes-1:0][wb_pkg::xlen-1:0]           ex_wdata,
  input  logic [num_pipes-1:0]                             ex_wen,
  input  logic [num_pipes-1:0][phys_addr_bits-1:0]         ex_preg,
  input  logic [num_pipes-1:0][phys_addr_bits-1:0]         ex_ppreg,
  output logic [num_pipes-1:0]                             ex_rdy,

  // Completion port
  output logic                                             complete_val,
  output logic [seq_num_bits-1:0]                          complete_seq_num,
  output logic [wb_pkg::arch_reg_bits-1:0]                 complete_waddr,
  output logic [wb_pkg::xlen-1:0]                          complete_wdata,
  output logic                                             complete_wen,
  output logic [phys_addr_bits-1:0]                        complete_preg,

  // Commit port
  output logic                                             commit_val,
  output logic [seq_num_bits-1:0]                          commit_seq_num,
  output logic [wb_pkg::xlen-1:0]                          commit_pc,
  output logic [wb_pkg::arch_reg_bits-1:0]                 commit_waddr,
  output logic [wb_pkg::xlen-1:0]                          commit_wdata,
  output logic                                             commit_wen,
  output logic [phys_addr_bits-1:0]                        commit_ppreg
);

  // Writeback register to reorder buffer
  logic                             wb_val;
  logic [seq_num_bits-1:0]          wb_seq_num;
  logic [wb_pkg::xlen-1:0]          wb_pc;
  logic [wb_pkg::arch_reg_bits-1:0] wb_waddr;
  logic [wb_pkg::xlen-1:0]          wb_wdata;
  logic                             wb_wen;
  logic [phys_addr_bits-1:0]        wb_ppreg;

  writeback_stage #(
    .num_pipes      (num_pipes),
    .seq_num_bits   (seq_num_bits),
    .phys_addr_bits (phys_addr_bits)
  ) wb_i (
    .clk              (clk),
    .rst              (rst),
    .ex_val           (ex_val),
    .ex_pc            (ex_pc),
    .ex_seq_num       (ex_seq_num),
    .ex_waddr         (ex_waddr),
    .ex_wdata         (ex_wdata),
    .ex_wen           (ex_wen),
    .ex_preg          (ex_preg),
    .ex_ppreg         (ex_ppreg),
    .ex_rdy           (ex_rdy),
    .commit_val       (commit_val),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen),
    .complete_preg    (complete_preg),
    .wb_val           (wb_val),
    .wb_seq_num       (wb_seq_num),
    .wb_pc            (wb_pc),
    .wb_waddr         (wb_waddr),
    .wb_wdata         (wb_wdata),
    .wb_wen           (wb_wen),
    .wb_ppreg         (wb_ppreg)
  );

  reorder_buffer #(
    .seq_num_bits   (seq_num_bits),
    .phys_addr_bits (phys_addr_bits)
  ) rob_i (
    .clk            (clk),
    .rst            (rst),
    .wb_val         (wb_val),
    .wb_seq_num     (wb_seq_num),
    .wb_pc          (wb_pc),
    .wb_waddr       (wb_waddr),
    .wb_wdata       (wb_wdata),
    .wb_wen         (wb_wen),
    .wb_ppreg       (wb_ppreg),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .commit_pc      (commit_pc),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata),
    .commit_wen     (commit_wen),
    .commit_ppreg   (commit_ppreg)
  );

endmodule

//--- logic/writeback_stage.sv
//--------------------
// Writeback stage
// Picks the oldest finished result, announces it on the
// completion port and registers it for the reorder buffer
//--------------------

module writeback_stage #(
  parameter int num_pipes      = wb_pkg::num_pipes_default,
  parameter int seq_num_bits   = wb_pkg::seq_num_bits_default,
  parameter int phys_addr_bits = wb_pkg::phys_addr_bits_default
) (
  input  logic                                             clk,
  input  logic                                             rst,

  // Execute pipes
  input  logic [num_pipes-1:0]                             ex_val,
  input  logic [num_pipes-1:0][wb_pkg::xlen-1:0]           ex_pc,
  input  logic [num_pipes-1:0][seq_num_bits-1:0]           ex_seq_num,
  input  logic [num_pipes-1:0][wb_pkg::arch_reg_bits-1:0]  ex_waddr,
  input  logic [num_pipes-1:0][wb_pkg::xlen-1:0]           ex_wdata,
  input  logic [num_pipes-1:0]                             ex_wen,
  input  logic [num_pipes-1:0][phys_addr_bits-1:0]         ex_preg,
  input  logic [num_pipes-1:0][phys_addr_bits-1:0]         ex_ppreg,
  output logic [num_pipes-1:0]                             ex_rdy,

  // Commit feedback for the arbiter head
  input  logic                                             commit_val,

  // Completion port
  output logic                                             complete_val,
  output logic [seq_num_bits-1:0]                          complete_seq_num,
  output logic [wb_pkg::arch_reg_bits-1:0]                 complete_waddr,
  output logic [wb_pkg::xlen-1:0]                          complete_wdata,
  output logic                                             complete_wen,
  output logic [phys_addr_bits-1:0]                        complete_preg,

  // Registered result toward the reorder buffer
  output logic                                             wb_val,
  output logic [seq_num_bits-1:0]                          wb_seq_num,
  output logic [wb_pkg::xlen-1:0]                          wb_pc,
  output logic [wb_pkg::arch_reg_bits-1:0]                 wb_waddr,
  output logic [wb_pkg::xlen-1:0]                          wb_wdata,
  output logic                                             wb_wen,
  output logic [phys_addr_bits-1:0]                        wb_ppreg
);

  logic [num_pipes-1:0] gnt;

  seq_arbiter #(
    .num_pipes    (num_pipes),
    .seq_num_bits (seq_num_bits)
  ) arb_i (
    .clk        (clk),
    .rst        (rst),
    .val        (ex_val),
    .seq_num    (ex_seq_num),
    .commit_val (commit_val),
    .gnt        (gnt)
  );

  // Ready means granted, there is no other back-pressure
  assign ex_rdy = gnt;

  //--------------------
  // Masked OR select
  //--------------------

  logic                             sel_val;
  logic [wb_pkg::xlen-1:0]          sel_pc;
  logic [seq_num_bits-1:0]          sel_seq_num;
  logic [wb_pkg::arch_reg_bits-1:0] sel_waddr;
  logic [wb_pkg::xlen-1:0]          sel_wdata;
  logic                             sel_wen;
  logic [phys_addr_bits-1:0]        sel_preg;
  logic [phys_addr_bits-1:0]        sel_ppreg;

  always_comb begin
    sel_val     = 1'b0;
    sel_pc      = '0;
    sel_seq_num = '0;
    sel_waddr   = '0;
    sel_wdata   = '0;
    sel_wen     = 1'b0;
    sel_preg    = '0;
    sel_ppreg   = '0;
    for (int p = 0; p < num_pipes; p++) begin
      sel_val     |= ex_val[p] & gnt[p];
      sel_pc      |= ex_pc[p] & {wb_pkg::xlen{gnt[p]}};
      sel_seq_num |= ex_seq_num[p] & {seq_num_bits{gnt[p]}};
      sel_waddr   |= ex_waddr[p] & {wb_pkg::arch_reg_bits{gnt[p]}};
      sel_wdata   |= ex_wdata[p] & {wb_pkg::xlen{gnt[p]}};
      sel_wen     |= ex_wen[p] & gnt[p];
      sel_preg    |= ex_preg[p] & {phys_addr_bits{gnt[p]}};
      sel_ppreg   |= ex_ppreg[p] & {phys_addr_bits{gnt[p]}};
    end
  end

  // Completion is announced in the transfer cycle itself
  assign complete_val     = sel_val;
  assign complete_seq_num = sel_seq_num;
  assign complete_waddr   = sel_waddr;
  assign complete_wdata   = sel_wdata;
  assign complete_wen     = sel_wen && (sel_waddr != '0);
  assign complete_preg    = sel_preg;

  //--------------------
  // Writeback register
  //--------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_val <= 1'b0;
    end else begin
      wb_val <= sel_val;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_val) begin
      wb_seq_num <= sel_seq_num;
      wb_pc      <= sel_pc;
      wb_waddr   <= sel_waddr;
      wb_wdata   <= sel_wdata;
      wb_wen     <= sel_wen;
      wb_ppreg   <= sel_ppreg;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the writeback and commit testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_writeback_commit_unit

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -f src.f --top-module "$top" -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/V$top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- src.f
logic/wb_pkg.sv
logic/seq_arbiter.sv
logic/writeback_stage.sv
logic/reorder_buffer.sv
logic/writeback_commit_unit.sv
verif/tb_writeback_commit_unit.sv

//--- verif/tb_writeback_commit_unit.sv
//--------------------
// Writeback and commit testbench
// Out-of-order results from three pipes, checked by
// assertions and a table of issued sequence numbers
//--------------------

module tb_writeback_commit_unit;

  localparam int num_pipes      = 3;
  localparam int seq_num_bits   = 3;
  localparam int phys_addr_bits = 6;
  localparam int arch_bits      = wb_pkg::arch_reg_bits;
  localparam int depth          = 8;
  localparam int num_blocks     = 24;
  localparam int hold_limit     = 200;
  localparam int drain_limit    = 400;

  logic clk;
  logic rst;

  logic [num_pipes-1:0]                            ex_val;
  logic [num_pipes-1:0][wb_pkg::xlen-1:0]          ex_pc;
  logic [num_pipes-1:0][seq_num_bits-1:0]          ex_seq_num;
  logic [num_pipes-1:0][arch_bits-1:0]             ex_waddr;
  logic [num_pipes-1:0][wb_pkg::xlen-1:0]          ex_wdata;
  logic [num_pipes-1:0]                            ex_wen;
  logic [num_pipes-1:0][phys_addr_bits-1:0]        ex_preg;
  logic [num_pipes-1:0][phys_addr_bits-1:0]        ex_ppreg;
  logic [num_pipes-1:0]                            ex_rdy;

  logic                      complete_val;
  logic [seq_num_bits-1:0]   complete_seq_num;
  logic [arch_bits-1:0]      complete_waddr;
  logic [wb_pkg::xlen-1:0]   complete_wdata;
  logic                      complete_wen;
  logic [phys_addr_bits-1:0] complete_preg;

  logic                      commit_val;
  logic [seq_num_bits-1:0]   commit_seq_num;
  logic [wb_pkg::xlen-1:0]   commit_pc;
  logic [arch_bits-1:0]      commit_waddr;
  logic [wb_pkg::xlen-1:0]   commit_wdata;
  logic                      commit_wen;
  logic [phys_addr_bits-1:0] commit_ppreg;

  writeback_commit_unit #(
    .num_pipes      (num_pipes),
    .seq_num_bits   (seq_num_bits),
    .phys_addr_bits (phys_addr_bits)
  ) dut_i (
    .clk              (clk),
    .rst              (rst),
    .ex_val           (ex_val),
    .ex_pc            (ex_pc),
    .ex_seq_num       (ex_seq_num),
    .ex_waddr         (ex_waddr),
    .ex_wdata         (ex_wdata),
    .ex_wen           (ex_wen),
    .ex_preg          (ex_preg),
    .ex_ppreg         (ex_ppreg),
    .ex_rdy           (ex_rdy),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen),
    .complete_preg    (complete_preg),
    .commit_val       (commit_val),
    .commit_seq_num   (commit_seq_num),
    .commit_pc        (commit_pc),
    .commit_waddr     (commit_waddr),
    .commit_wdata     (commit_wdata),
    .commit_wen       (commit_wen),
    .commit_ppreg     (commit_ppreg)
  );

  //--------------------
  // Table and counters
  //--------------------

  // Expected fields, indexed by sequence number
  logic [wb_pkg::xlen-1:0]   exp_pc    [depth];
  logic [arch_bits-1:0]      exp_waddr [depth];
  logic [wb_pkg::xlen-1:0]   exp_wdata [depth];
  logic                      exp_wen   [depth];
  logic [phys_addr_bits-1:0] exp_preg  [depth];
  logic [phys_addr_bits-1:0] exp_ppreg [depth];

  // Serial numbers tell one use of a sequence number from the next
  int issue_serial [depth] = '{default: 0};
  int xfer_serial  [depth] = '{default: -1};
  int xfer_edge    [depth] = '{default: 0};

  int pend_seq [num_pipes][$];
  int pend_dly [num_pipes][$];
  int idle_cnt    [num_pipes] = '{default: 0};
  int hold_cnt    [num_pipes] = '{default: 0};
  int present_cnt [num_pipes] = '{default: 0};
  int xfer_cnt    [num_pipes] = '{default: 0};

  int issued_count  = 0;
  int next_serial   = 0;
  int next_seq      = 0;
  int commit_count  = 0;
  int edge_cnt      = 0;
  int in_unit       = 0;
  int max_in_unit   = 0;
  int denied_cycles = 0;
  int prop_errors   = 0;
  int data_errors   = 0;
  int reach_errors  = 0;
  int timed_out     = 0;

  // Head as seen from the commits observed here
  logic [seq_num_bits-1:0] tb_head;

  always #50 clk = ~clk;

  // Expected grant goes to the valid pipe nearest the head
  function automatic logic [num_pipes-1:0] oldest_grant(
    input logic [num_pipes-1:0]                   val,
    input logic [num_pipes-1:0][seq_num_bits-1:0] seqs,
    input logic [seq_num_bits-1:0]                head
  );
    int best;
    int age;
    logic [num_pipes-1:0] g;
    best = depth;
    g    = '0;
    for (int p = 0; p < num_pipes; p++) begin
      age = (int'(seqs[p]) - int'(head) + depth) % depth;
      if (val[p] && age < best) begin
        best = age;
        g    = '0;
        g[p] = 1'b1;
      end
    end
    return g;
  endfunction

  //--------------------
  // Protocol assertions
  //--------------------

  a_reset_quiet: assert property (
    @(posedge clk) $fell(rst) |-> (ex_rdy == '0 && !complete_val && !commit_val)
  ) else begin
    prop_errors++;
    $display("ERROR at %0t: outputs active right after reset", $time);
  end

  a_one_ready: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(ex_rdy) && ((ex_rdy & ~ex_val) == '0)
  ) else begin
    prop_errors++;
    $display("ERROR at %0t: several ready lines or ready to an idle pipe", $time);
  end

  a_oldest_first: assert property (
    @(posedge clk) disable iff (rst)
    ex_rdy == oldest_grant(ex_val, ex_seq_num, tb_head)
  ) else begin
    prop_errors++;
    $display("[FAIL] %0t ex_rdy expected %b got %b", $time,
             oldest_grant($sampled(ex_val), $sampled(ex_seq_num), $sampled(tb_head)),
             $sampled(ex_rdy));
  end

  a_complete_val: assert property (
    @(posedge clk) disable iff (rst)
    complete_val == ((ex_val & ex_rdy) != '0)
  ) else begin
    prop_errors++;
    $display("[FAIL] %0t complete_val expected %b got %b", $time,
             $sampled((ex_val & ex_rdy) != '0), $sampled(complete_val));
  end

  a_complete_r0: assert property (
    @(posedge clk) disable iff (rst)
    (complete_val && complete_waddr == '0) |-> !complete_wen
  ) else begin
    prop_errors++;
    $display("ERROR at %0t: completion writes register zero", $time);
  end

  // Denied pipes wait with their fields unchanged
  for (genvar gp = 0; gp < num_pipes; gp++) begin : g_hold
    a_hold: assert property (
      @(posedge clk) disable iff (rst)
      (ex_val[gp] && !ex_rdy[gp]) |=>
        (ex_val[gp] && $stable(ex_seq_num[gp]) && $stable(ex_pc[gp]) &&
         $stable(ex_waddr[gp]) && $stable(ex_wdata[gp]) && $stable(ex_wen[gp]) &&
         $stable(ex_preg[gp]) && $stable(ex_ppreg[gp]))
    ) else begin
      prop_errors++;
      $display("ERROR at %0t: pipe %0d dropped or changed a waiting result", $time, gp);
    end
  end

  //--------------------
  // Scoreboard
  //--------------------

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    assert (got === want) else begin
      data_errors++;
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, want, got);
    end
  endtask

  always @(posedge clk) begin
    int s;
    if (rst) begin
      tb_head <= '0;
    end else begin
      edge_cnt++;
      for (int p = 0; p < num_pipes; p++) begin
        if (ex_val[p] && ex_rdy[p]) begin
          s = int'(ex_seq_num[p]);
          compare_field("complete_seq_num", 32'(complete_seq_num), 32'(ex_seq_num[p]));
          compare_field("complete_waddr", 32'(complete_waddr), 32'(exp_waddr[s]));
          compare_field("complete_wdata", complete_wdata, exp_wdata[s]);
          compare_field("complete_preg", 32'(complete_preg), 32'(exp_preg[s]));
          compare_field("complete_wen", 32'(complete_wen),
                        32'(exp_wen[s] && exp_waddr[s] != '0));
          xfer_serial[s] = issue_serial[s];
          xfer_edge[s]   = edge_cnt;
          xfer_cnt[p]++;
          in_unit++;
        end
      end
      if ((ex_val & ~ex_rdy) != '0) begin
        denied_cycles++;
      end
      if (commit_val) begin
        s = int'(commit_seq_num);
        compare_field("commit_seq_num", 32'(commit_seq_num), 32'(tb_head));
        assert (xfer_serial[s] == issue_serial[s] && edge_cnt - xfer_edge[s] >= 2) else begin
          data_errors++;
          $display("ERROR at %0t: sequence %0d committed twice or too early", $time, s);
        end
        compare_field("commit_pc", commit_pc, exp_pc[s]);
        compare_field("commit_waddr", 32'(commit_waddr), 32'(exp_waddr[s]));
        compare_field("commit_wdata", commit_wdata, exp_wdata[s]);
        compare_field("commit_wen", 32'(commit_wen), 32'(exp_wen[s] && exp_waddr[s] != '0));
        compare_field("commit_ppreg", 32'(commit_ppreg), 32'(exp_ppreg[s]));
        xfer_serial[s] = -1;
        commit_count++;
        in_unit--;
        tb_head <= tb_head + 3'd1;
      end
      if (in_unit > max_in_unit) begin
        max_in_unit = in_unit;
      end
    end
  end

  //--------------------
  // Stimulus
  //--------------------

  // Random fields for the next n numbers spread over the pipes
  task automatic issue_block(input int n, input bit fill);
    int order [depth];
    int j;
    int tmp;
    int s;
    int p;
    for (int i = 0; i < n; i++) begin
      order[i] = i;
    end
    for (int i = n - 1; i > 0; i--) begin
      j        = int'($urandom % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    // Oldest goes last so the rest fill the reorder buffer first
    if (fill) begin
      for (int i = 0; i < n; i++) begin
        if (order[i] == 0) begin
          order[i]     = order[n - 1];
          order[n - 1] = 0;
        end
      end
    end
    for (int i = 0; i < n; i++) begin
      s = (next_seq + order[i]) % depth;
      p = int'($urandom % num_pipes);
      next_serial++;
      issue_serial[s] = next_serial;
      exp_pc[s]       = $urandom;
      exp_waddr[s]    = ($urandom % 4 == 0) ? '0 : arch_bits'($urandom);
      exp_wdata[s]    = $urandom;
      exp_wen[s]      = 1'($urandom);
      exp_preg[s]     = phys_addr_bits'($urandom);
      exp_ppreg[s]    = phys_addr_bits'($urandom);
      pend_seq[p].push_back(s);
      pend_dly[p].push_back((fill && order[i] == 0) ? 12 : int'($urandom % 4));
    end
    next_seq     = (next_seq + n) % depth;
    issued_count = issued_count + n;
  endtask

  // One falling edge of pipe activity
  task automatic step_pipes();
    int s;
    for (int p = 0; p < num_pipes; p++) begin
      if (ex_val[p]) begin
        if (xfer_cnt[p] == present_cnt[p]) begin
          ex_val[p]   = 1'b0;
          idle_cnt[p] = 0;
          hold_cnt[p] = 0;
        end else begin
          hold_cnt[p]++;
          if (hold_cnt[p] > hold_limit && timed_out == 0) begin
            timed_out = 1;
            $display("ERROR: pipe %0d got no ready within %0d cycles", p, hold_limit);
          end
        end
      end
      if (!ex_val[p] && pend_seq[p].size() > 0) begin
        if (idle_cnt[p] < pend_dly[p][0]) begin
          idle_cnt[p]++;
        end else begin
          s = pend_seq[p].pop_front();
          pend_dly[p].delete(0);
          ex_val[p]     = 1'b1;
          ex_seq_num[p] = seq_num_bits'(s);
          ex_pc[p]      = exp_pc[s];
          ex_waddr[p]   = exp_waddr[s];
          ex_wdata[p]   = exp_wdata[s];
          ex_wen[p]     = exp_wen[s];
          ex_preg[p]    = exp_preg[s];
          ex_ppreg[p]   = exp_ppreg[s];
          present_cnt[p]++;
        end
      end
    end
  endtask

  task automatic drain_block();
    int waited;
    waited = 0;
    while (commit_count != issued_count && timed_out == 0) begin
      @(negedge clk);
      step_pipes();
      waited++;
      if (waited > drain_limit) begin
        timed_out = 1;
        $display("ERROR: block did not commit within %0d cycles", drain_limit);
      end
    end
  endtask

  initial begin
    int n;
    clk        = 1'b0;
    rst        = 1'b1;
    ex_val     = '0;
    ex_pc      = '0;
    ex_seq_num = '0;
    ex_waddr   = '0;
    ex_wdata   = '0;
    ex_wen     = '0;
    ex_preg    = '0;
    ex_ppreg   = '0;
    void'($urandom(64472));
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);

    // Every fourth block fills the reorder buffer completely
    for (int b = 0; b < num_blocks && timed_out == 0; b++) begin
      if (b % 4 == 3) begin
        issue_block(depth, 1'b1);
      end else begin
        n = 1 + int'($urandom % depth);
        issue_block(n, 1'b0);
      end
      drain_block();
    end
    repeat (4) @(negedge clk);

    if (timed_out == 0) begin
      if (commit_count != issued_count) begin
        reach_errors++;
        $display("ERROR: %0d numbers issued but %0d committed", issued_count, commit_count);
      end
      if (max_in_unit < depth) begin
        reach_errors++;
        $display("ERROR: reorder buffer never held %0d results", depth);
      end
      if (denied_cycles == 0) begin
        reach_errors++;
        $display("ERROR: no pipe was ever kept waiting");
      end
    end

    $display("Errors: assertions %0d, data %0d, coverage %0d, timeouts %0d",
             prop_errors, data_errors, reach_errors, timed_out);
    if (prop_errors + data_errors + reach_errors + timed_out == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
